/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_mesh_pod_row -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

/* common/mesh_row_pkg.sv */
// ######################################
// shared widths, opcodes and link types
// for the mesh row; modules pull them in
// with a wildcard import
// ######################################

package mesh_row_pkg;

  localparam int x_cord_width_gp = 4;
  localparam int addr_width_gp = 4;
  localparam int data_width_gp = 32;

  // widest payload view is the request, plus one spare bit
  localparam int payload_width_gp = addr_width_gp + data_width_gp + 1;

  typedef enum logic [1:0] {
    op_store    = 2'd0,
    op_load     = 2'd1,
    op_response = 2'd2,
    op_invalid  = 2'd3
  } mesh_op_e;

  typedef enum logic {
    status_ok     = 1'b0,
    status_bad_op = 1'b1
  } mesh_status_e;

  typedef struct packed {
    logic [payload_width_gp-addr_width_gp-data_width_gp-1:0] pad;
    logic [addr_width_gp-1:0]                                addr;
    logic [data_width_gp-1:0]                                data;
  } mesh_req_s;

  typedef struct packed {
    logic [payload_width_gp-data_width_gp-2:0] pad;
    mesh_status_e                              status;
    logic [data_width_gp-1:0]                  data;
  } mesh_resp_s;

  // same word, read by opcode
  typedef union packed {
    mesh_req_s  req;
    mesh_resp_s resp;
  } mesh_payload_u;

  typedef struct packed {
    logic [x_cord_width_gp-1:0] dst_x;
    logic [x_cord_width_gp-1:0] src_x;
    mesh_op_e                   op;
    mesh_payload_u              payload;
  } mesh_packet_s;

  typedef struct packed {
    logic         v;
    mesh_packet_s pkt;
  } mesh_link_s;

endpackage

/* files.f */
+incdir+verification
common/mesh_row_pkg.sv
hw/mesh_tile/mesh_router.sv
hw/mesh_tile/mesh_endpoint.sv
hw/mesh_pod.sv
hw/mesh_pod_row.sv
verification/tb_mesh_pod_row.sv

/* hw/mesh_pod.sv */
`timescale 1ns/1ps
// ######################################
// one pod: a row of router + scratchpad
// tiles, x numbered from the pod index
// ######################################

module mesh_pod
  import mesh_row_pkg::*;
#(
  parameter int num_tiles_x_p = 2,
  parameter int pod_index_p = 0
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  mesh_link_s w_link_i,
  output logic       w_ready_o,
  output mesh_link_s w_link_o,
  input  logic       w_ready_i,
  input  mesh_link_s e_link_i,
  output logic       e_ready_o,
  output mesh_link_s e_link_o,
  input  logic       e_ready_i
);

  // tiles leave reset one cycle after the row
  logic reset_r;

  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  for (genvar t = 0; t < num_tiles_x_p; t++) begin : tx
    // x 0 belongs to the west host
    localparam logic [x_cord_width_gp-1:0] tile_x_lp =
      x_cord_width_gp'(pod_index_p * num_tiles_x_p + t + 1);

    mesh_link_s w_link_li;
    mesh_link_s w_link_lo;
    mesh_link_s e_link_li;
    mesh_link_s e_link_lo;
    mesh_link_s req_link;
    mesh_link_s resp_link;
    logic       w_ready_li;
    logic       w_ready_lo;
    logic       e_ready_li;
    logic       e_ready_lo;
    logic       req_ready;
    logic       resp_ready;

    mesh_router #(
      .my_x_p(tile_x_lp)
    ) router (
      .clk_i    (clk_i),
      .reset_i  (reset_r),
      .w_link_i (w_link_li),
      .e_link_i (e_link_li),
      .p_link_i (resp_link),
      .w_ready_o(w_ready_lo),
      .e_ready_o(e_ready_lo),
      .p_ready_o(resp_ready),
      .w_link_o (w_link_lo),
      .e_link_o (e_link_lo),
      .p_link_o (req_link),
      .w_ready_i(w_ready_li),
      .e_ready_i(e_ready_li),
      .p_ready_i(req_ready)
    );

    mesh_endpoint #(
      .my_x_p(tile_x_lp)
    ) endpoint (
      .clk_i       (clk_i),
      .reset_i     (reset_r),
      .req_link_i  (req_link),
      .req_ready_o (req_ready),
      .resp_link_o (resp_link),
      .resp_ready_i(resp_ready)
    );

    // west side is the pod edge or the previous tile
    if (t == 0) begin : w_edge
      assign w_link_li = w_link_i;
      assign w_ready_li = w_ready_i;
    end else begin : w_nbr
      assign w_link_li = tx[t-1].e_link_lo;
      assign w_ready_li = tx[t-1].e_ready_lo;
    end

    if (t == num_tiles_x_p - 1) begin : e_edge
      assign e_link_li = e_link_i;
      assign e_ready_li = e_ready_i;
    end else begin : e_nbr
      assign e_link_li = tx[t+1].w_link_lo;
      assign e_ready_li = tx[t+1].w_ready_lo;
    end
  end

  assign w_link_o = tx[0].w_link_lo;
  assign w_ready_o = tx[0].w_ready_lo;
  assign e_link_o = tx[num_tiles_x_p-1].e_link_lo;
  assign e_ready_o = tx[num_tiles_x_p-1].e_ready_lo;

endmodule

/* hw/mesh_pod_row.sv */
`timescale 1ns/1ps
// ######################################
// top level: pods joined east to west,
// outer links go to the edge hosts
// ######################################

module mesh_pod_row
  import mesh_row_pkg::*;
#(
  parameter int num_pods_x_p = 2,
  parameter int num_tiles_x_p = 2
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  mesh_link_s hor_w_link_i,
  output logic       hor_w_ready_o,
  output mesh_link_s hor_w_link_o,
  input  logic       hor_w_ready_i,
  input  mesh_link_s hor_e_link_i,
  output logic       hor_e_ready_o,
  output mesh_link_s hor_e_link_o,
  input  logic       hor_e_ready_i
);

  for (genvar x = 0; x < num_pods_x_p; x++) begin : px
    mesh_link_s w_link_li;
    mesh_link_s w_link_lo;
    mesh_link_s e_link_li;
    mesh_link_s e_link_lo;
    logic       w_ready_li;
    logic       w_ready_lo;
    logic       e_ready_li;
    logic       e_ready_lo;

    mesh_pod #(
      .num_tiles_x_p(num_tiles_x_p),
      .pod_index_p  (x)
    ) pod (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_link_i (w_link_li),
      .w_ready_o(w_ready_lo),
      .w_link_o (w_link_lo),
      .w_ready_i(w_ready_li),
      .e_link_i (e_link_li),
      .e_ready_o(e_ready_lo),
      .e_link_o (e_link_lo),
      .e_ready_i(e_ready_li)
    );

    // west neighbor, or the west host for pod 0
    if (x == 0) begin : w_edge
      assign w_link_li = hor_w_link_i;
      assign w_ready_li = hor_w_ready_i;
    end else begin : w_nbr
      assign w_link_li = px[x-1].e_link_lo;
      assign w_ready_li = px[x-1].e_ready_lo;
    end

    if (x == num_pods_x_p - 1) begin : e_edge
      assign e_link_li = hor_e_link_i;
      assign e_ready_li = hor_e_ready_i;
    end else begin : e_nbr
      assign e_link_li = px[x+1].w_link_lo;
      assign e_ready_li = px[x+1].w_ready_lo;
    end
  end

  assign hor_w_link_o = px[0].w_link_lo;
  assign hor_w_ready_o = px[0].w_ready_lo;
  assign hor_e_link_o = px[num_pods_x_p-1].e_link_lo;
  assign hor_e_ready_o = px[num_pods_x_p-1].e_ready_lo;

endmodule

/* hw/mesh_tile/mesh_endpoint.sv */
`timescale 1ns/1ps
// ######################################
// tile scratchpad; answers each store or
// load with one response a cycle later
// ######################################

module mesh_endpoint
  import mesh_row_pkg::*;
#(
  parameter logic [x_cord_width_gp-1:0] my_x_p = x_cord_width_gp'(1)
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  mesh_link_s req_link_i,
  output logic       req_ready_o,
  output mesh_link_s resp_link_o,
  input  logic       resp_ready_i
);

  localparam int words_lp = 1 << addr_width_gp;

  logic [data_width_gp-1:0] mem_r [words_lp];
  mesh_req_s                req;
  mesh_packet_s             resp_pkt;
  logic                     accept;
  logic                     resp_v_r;
  mesh_packet_s             resp_pkt_r;

  // request view of the incoming payload
  assign req = req_link_i.pkt.payload.req;

  // held off while a response sits in the register
  assign req_ready_o = !resp_v_r;
  assign accept = req_link_i.v && req_ready_o;

  always_comb begin
    resp_pkt = '0;
    resp_pkt.dst_x = req_link_i.pkt.src_x;
    resp_pkt.src_x = my_x_p;
    resp_pkt.op = op_response;
    case (req_link_i.pkt.op)
      op_store: begin
        resp_pkt.payload.resp.status = status_ok;
        resp_pkt.payload.resp.data = req.data;
      end
      op_load: begin
        resp_pkt.payload.resp.status = status_ok;
        resp_pkt.payload.resp.data = mem_r[req.addr];
      end
      default: begin
        resp_pkt.payload.resp.status = status_bad_op;
        resp_pkt.payload.resp.data = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept && (req_link_i.pkt.op == op_store)) begin
      mem_r[req.addr] <= req.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (!resp_v_r) begin
      resp_v_r <= req_link_i.v;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) resp_pkt_r <= resp_pkt;
  end

  assign resp_link_o = '{v: resp_v_r, pkt: resp_pkt_r};

endmodule

/* hw/mesh_tile/mesh_router.sv */
`timescale 1ns/1ps
// ######################################
// three-port x-only router; one register
// per output and a two-way round robin
// between the inputs that can reach it
// ######################################

module mesh_router
  import mesh_row_pkg::*;
#(
  parameter logic [x_cord_width_gp-1:0] my_x_p = x_cord_width_gp'(1)
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  mesh_link_s w_link_i,
  input  mesh_link_s e_link_i,
  input  mesh_link_s p_link_i,
  output logic       w_ready_o,
  output logic       e_ready_o,
  output logic       p_ready_o,
  output mesh_link_s w_link_o,
  output mesh_link_s e_link_o,
  output mesh_link_s p_link_o,
  input  logic       w_ready_i,
  input  logic       e_ready_i,
  input  logic       p_ready_i
);

  // gnt[0] for the first source, gnt[1] for the second
  function automatic logic [1:0] rr_grant(input logic req_a, input logic req_b,
                                          input logic last_b, input logic free);
    logic pick_b;
    pick_b = req_b && (!req_a || !last_b);
    return {free && pick_b, free && req_a && !pick_b};
  endfunction

  logic         w_to_e;
  logic         w_to_p;
  logic         e_to_w;
  logic         e_to_p;
  logic         p_to_w;
  logic         p_to_e;
  logic         w_free;
  logic         e_free;
  logic         p_free;
  logic [1:0]   w_gnt;
  logic [1:0]   e_gnt;
  logic [1:0]   p_gnt;
  logic         w_v_r;
  logic         e_v_r;
  logic         p_v_r;
  logic         w_last_r;
  logic         e_last_r;
  logic         p_last_r;
  mesh_packet_s w_pkt_r;
  mesh_packet_s e_pkt_r;
  mesh_packet_s p_pkt_r;

  // steering, never back out the way a packet came
  assign w_to_e = w_link_i.v && (w_link_i.pkt.dst_x > my_x_p);
  assign w_to_p = w_link_i.v && !(w_link_i.pkt.dst_x > my_x_p);
  assign e_to_w = e_link_i.v && (e_link_i.pkt.dst_x < my_x_p);
  assign e_to_p = e_link_i.v && !(e_link_i.pkt.dst_x < my_x_p);
  assign p_to_w = p_link_i.v && (p_link_i.pkt.dst_x < my_x_p);
  assign p_to_e = p_link_i.v && !(p_link_i.pkt.dst_x < my_x_p);

  // an output takes a new packet when empty or draining now
  assign w_free = !w_v_r || w_ready_i;
  assign e_free = !e_v_r || e_ready_i;
  assign p_free = !p_v_r || p_ready_i;

  // west out from {p, e}, east out from {p, w}, proc out from {e, w}
  assign w_gnt = rr_grant(e_to_w, p_to_w, w_last_r, w_free);
  assign e_gnt = rr_grant(w_to_e, p_to_e, e_last_r, e_free);
  assign p_gnt = rr_grant(w_to_p, e_to_p, p_last_r, p_free);

  // each input wants exactly one output, so at most one grant is set
  assign w_ready_o = e_gnt[0] | p_gnt[0];
  assign e_ready_o = w_gnt[0] | p_gnt[1];
  assign p_ready_o = w_gnt[1] | e_gnt[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_v_r    <= 1'b0;
      e_v_r    <= 1'b0;
      p_v_r    <= 1'b0;
      w_last_r <= 1'b0;
      e_last_r <= 1'b0;
      p_last_r <= 1'b0;
    end else begin
      if (w_free) w_v_r <= |w_gnt;
      if (e_free) e_v_r <= |e_gnt;
      if (p_free) p_v_r <= |p_gnt;
      if (|w_gnt) w_last_r <= w_gnt[1];
      if (|e_gnt) e_last_r <= e_gnt[1];
      if (|p_gnt) p_last_r <= p_gnt[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (|w_gnt) w_pkt_r <= w_gnt[1] ? p_link_i.pkt : e_link_i.pkt;
    if (|e_gnt) e_pkt_r <= e_gnt[1] ? p_link_i.pkt : w_link_i.pkt;
    if (|p_gnt) p_pkt_r <= p_gnt[1] ? e_link_i.pkt : w_link_i.pkt;
  end

  assign w_link_o = '{v: w_v_r, pkt: w_pkt_r};
  assign e_link_o = '{v: e_v_r, pkt: e_pkt_r};
  assign p_link_o = '{v: p_v_r, pkt: p_pkt_r};

endmodule

/* verification/mesh_row_checks.svh */
// ######################################
// compare tasks and the reference memory
// for the mesh row testbench; included
// inside the testbench module
// ######################################

`ifndef MESH_ROW_CHECKS_SVH
`define MESH_ROW_CHECKS_SVH

int error_count = 0;
int check_count = 0;

// expected scratchpad words, by tile x and word address
logic [data_width_gp-1:0] ref_mem [1 << x_cord_width_gp][1 << addr_width_gp];
bit                       ref_known [1 << x_cord_width_gp][1 << addr_width_gp];

task automatic check_packet(input mesh_packet_s got, input mesh_packet_s exp,
                            input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("ERR %0t: %s packet got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_status(input mesh_status_e got, input mesh_status_e exp,
                            input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("ERR %0t: %s status got %s expected %s", $time, what, got.name(), exp.name());
  end
endtask

task automatic ref_write(input int x, input int addr, input logic [data_width_gp-1:0] data);
  ref_mem[x][addr] = data;
  ref_known[x][addr] = 1'b1;
endtask

`endif

/* verification/tb_mesh_pod_row.sv */
`timescale 1ns/1ps
// ######################################
// directed and random tests of the mesh
// row, driven from both edge hosts
// ######################################

module tb_mesh_pod_row
  import mesh_row_pkg::*;
();

  localparam int num_pods_lp = 2;
  localparam int num_tiles_lp = 2;
  localparam int num_x_lp = num_pods_lp * num_tiles_lp;
  localparam int east_x_lp = num_x_lp + 1;
  localparam int timeout_lp = 200;

  logic        clk;
  logic        reset;
  mesh_link_s  w_link_in;
  mesh_link_s  e_link_in;
  mesh_link_s  w_link_out;
  mesh_link_s  e_link_out;
  logic        w_ready_in;
  logic        e_ready_in;
  logic        w_ready_out;
  logic        e_ready_out;
  logic [31:0] lfsr_r;
  int          tests_run;
  int          tests_failed;
  int          errors_before;
  int          requests_sent;
  int          responses_seen;

  `include "mesh_row_checks.svh"

  mesh_pod_row #(
    .num_pods_x_p (num_pods_lp),
    .num_tiles_x_p(num_tiles_lp)
  ) uut (
    .clk_i        (clk),
    .reset_i      (reset),
    .hor_w_link_i (w_link_in),
    .hor_w_ready_o(w_ready_out),
    .hor_w_link_o (w_link_out),
    .hor_w_ready_i(w_ready_in),
    .hor_e_link_i (e_link_in),
    .hor_e_ready_o(e_ready_out),
    .hor_e_link_o (e_link_out),
    .hor_e_ready_i(e_ready_in)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // every beat leaving either edge, taken on the next rising edge
  always @(negedge clk) begin
    if (!reset && w_link_out.v === 1'b1 && w_ready_in === 1'b1) responses_seen++;
    if (!reset && e_link_out.v === 1'b1 && e_ready_in === 1'b1) responses_seen++;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_r[0]};
      lfsr_r = (lfsr_r >> 1) ^ (lfsr_r[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic mesh_packet_s make_request(input int dst, input int src,
                                                input mesh_op_e op, input int addr,
                                                input logic [31:0] data);
    mesh_packet_s p;
    p = '0;
    p.dst_x = x_cord_width_gp'(dst);
    p.src_x = x_cord_width_gp'(src);
    p.op = op;
    p.payload.req.addr = addr_width_gp'(addr);
    p.payload.req.data = data;
    return p;
  endfunction

  // response goes back to the requester, source is the tile
  function automatic mesh_packet_s make_response(input int dst, input int src,
                                                 input mesh_status_e status,
                                                 input logic [31:0] data);
    mesh_packet_s p;
    p = '0;
    p.dst_x = x_cord_width_gp'(dst);
    p.src_x = x_cord_width_gp'(src);
    p.op = op_response;
    p.payload.resp.status = status;
    p.payload.resp.data = data;
    return p;
  endfunction

  task automatic stop_on_timeout(input string why);
    $display("timeout: %s", why);
    $display("Errors found");
    $finish;
  endtask

  // hold the packet until the edge takes it
  task automatic send_request(input bit from_east, input mesh_packet_s pkt);
    int   waited;
    logic ready;
    waited = 0;
    if (from_east) e_link_in = '{v: 1'b1, pkt: pkt};
    else w_link_in = '{v: 1'b1, pkt: pkt};
    do begin
      @(negedge clk);
      ready = from_east ? e_ready_out : w_ready_out;
      waited++;
    end while (!ready && waited < timeout_lp);
    if (!ready) begin
      if (from_east) stop_on_timeout("east edge never took a request");
      else stop_on_timeout("west edge never took a request");
    end else begin
      @(posedge clk);
      #2;
      w_link_in.v = 1'b0;
      e_link_in.v = 1'b0;
      requests_sent++;
    end
  endtask

  task automatic get_response(input bit at_east, output mesh_packet_s pkt);
    int         waited;
    mesh_link_s link;
    waited = 0;
    do begin
      @(negedge clk);
      link = at_east ? e_link_out : w_link_out;
      waited++;
    end while (link.v !== 1'b1 && waited < timeout_lp);
    if (link.v !== 1'b1) begin
      if (at_east) stop_on_timeout("no response at east edge");
      else stop_on_timeout("no response at west edge");
    end else begin
      pkt = link.pkt;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic expect_quiet(input bit at_east, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if ((at_east ? e_link_out.v : w_link_out.v) !== 1'b0) begin
        error_count++;
        $display("extra response at %s edge, time %0t", at_east ? "east" : "west", $time);
      end
    end
    @(posedge clk);
    #2;
  endtask

  // one request, its response back at the same edge
  task automatic transact(input bit east, input int x, input mesh_op_e op, input int addr,
                          input logic [31:0] data);
    int           host_x;
    mesh_packet_s got;
    mesh_packet_s exp;
    host_x = east ? east_x_lp : 0;
    if (op == op_store) exp = make_response(host_x, x, status_ok, data);
    else if (op == op_load) exp = make_response(host_x, x, status_ok, ref_mem[x][addr]);
    else exp = make_response(host_x, x, status_bad_op, '0);
    send_request(east, make_request(x, host_x, op, addr, data));
    get_response(east, got);
    check_packet(got, exp, $sformatf("tile %0d addr %0d", x, addr));
    check_status(got.payload.resp.status, exp.payload.resp.status,
                 $sformatf("tile %0d addr %0d", x, addr));
    if (op == op_store) ref_write(x, addr, data);
  endtask

  task automatic start_test();
    errors_before = error_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
      $display("test %s: FAILED", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic west_stores_loads();
    start_test();
    for (int x = 1; x <= num_x_lp; x++) begin
      transact(1'b0, x, op_store, x, {16'ha5a5, 8'(x), 8'h00});
    end
    for (int x = 1; x <= num_x_lp; x++) begin
      transact(1'b0, x, op_load, x, '0);
    end
    end_test("west stores and loads");
  endtask

  // one address shared by all tiles, and the west words must survive too
  task automatic east_stores_loads();
    start_test();
    for (int x = 1; x <= num_x_lp; x++) begin
      transact(1'b1, x, op_store, 8, {16'h5a5a, 8'(x), 8'h11});
    end
    for (int x = 1; x <= num_x_lp; x++) begin
      transact(1'b1, x, op_load, 8, '0);
      transact(1'b1, x, op_load, x, '0);
    end
    end_test("east stores and loads");
  endtask

  task automatic invalid_opcode();
    int x;
    x = num_tiles_lp + 1;
    start_test();
    transact(1'b0, x, op_invalid, x, 32'hdead_beef);
    transact(1'b0, x, op_load, x, '0);
    end_test("invalid opcode");
  endtask

  task automatic pass_through();
    mesh_packet_s pkt;
    mesh_packet_s got;
    start_test();
    pkt = make_request(east_x_lp, 0, op_store, 5, rand_bits(32));
    send_request(1'b0, pkt);
    get_response(1'b1, got);
    check_packet(got, pkt, "west to east pass-through");
    pkt = make_request(0, east_x_lp, op_load, 9, rand_bits(32));
    send_request(1'b1, pkt);
    get_response(1'b0, got);
    check_packet(got, pkt, "east to west pass-through");
    end_test("pass-through");
  endtask

  // responses pile up behind the west edge, then drain
  task automatic ordered_under_backpressure();
    mesh_packet_s expected[$];
    mesh_packet_s got;
    int           x;
    int           addr;
    int           hit;
    start_test();
    w_ready_in = 1'b0;
    for (int i = 0; i < 5; i++) begin
      x = (i % num_x_lp) + 1;
      addr = (i < num_x_lp) ? x : 8;
      expected.push_back(make_response(0, x, status_ok, ref_mem[x][addr]));
      send_request(1'b0, make_request(x, 0, op_load, addr, '0));
    end
    w_ready_in = 1'b1;
    for (int i = 0; i < 5; i++) begin
      get_response(1'b0, got);
      hit = -1;
      foreach (expected[j]) begin
        if (hit < 0 && expected[j].src_x == got.src_x) hit = j;
      end
      if (hit < 0) begin
        error_count++;
        $display("unexpected response from tile %0d at time %0t", got.src_x, $time);
      end else begin
        check_packet(got, expected[hit], "held load");
        expected.delete(hit);
      end
    end
    if (expected.size() != 0) begin
      error_count++;
      $display("%0d held loads never answered", expected.size());
    end
    expect_quiet(1'b0, 20);
    end_test("back-pressure ordering");
  endtask

  task automatic random_traffic();
    bit          east;
    int          x;
    int          addr;
    mesh_op_e    op;
    logic [31:0] data;
    int          sent_before;
    int          seen_before;
    start_test();
    sent_before = requests_sent;
    seen_before = responses_seen;
    for (int i = 0; i < 64; i++) begin
      east = 1'(rand_bits(1));
      x = int'(rand_bits(4)) % num_x_lp + 1;
      addr = int'(rand_bits(addr_width_gp));
      op = (rand_bits(1) != 0) ? op_load : op_store;
      data = rand_bits(32);
      // never load a word that was not written
      if (op == op_load && !ref_known[x][addr]) op = op_store;
      transact(east, x, op, addr, data);
    end
    expect_quiet(1'b0, 10);
    expect_quiet(1'b1, 10);
    if (responses_seen - seen_before != requests_sent - sent_before) begin
      error_count++;
      $display("response count %0d differs from request count %0d",
               responses_seen - seen_before, requests_sent - sent_before);
    end
    end_test("random traffic");
  endtask

  initial begin
    lfsr_r = 32'h0f9e4140;
    tests_run = 0;
    tests_failed = 0;
    requests_sent = 0;
    responses_seen = 0;
    reset = 1'b1;
    w_link_in = '0;
    e_link_in = '0;
    w_ready_in = 1'b1;
    e_ready_in = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    // pods hold their tiles in reset one cycle longer
    repeat (2) @(posedge clk);
    #2;
    west_stores_loads();
    east_stores_loads();
    invalid_opcode();
    pass_through();
    ordered_under_backpressure();
    random_traffic();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
